// File: sdr_ds_pkg.sv
// Downstream protocol constants, byte stream, command, sample and status types
package sdr_ds_pkg;

  localparam logic [15:0] ds_port_c = 16'd1024;
  localparam logic [7:0] ds_preamble0_c = 8'hef;
  localparam logic [7:0] ds_preamble1_c = 8'hfe;
  localparam logic [7:0] ds_kind_data_c = 8'h01;
  localparam logic [7:0] ds_kind_disc_c = 8'h02;
  localparam logic [7:0] ds_kind_runstop_c = 8'h04;
  localparam logic [7:0] ds_endpoint_c = 8'h02;
  localparam logic [7:0] ds_sync_c = 8'h7f;
  localparam int ds_samples_per_frame_c = 63;
  localparam int ds_frames_per_packet_c = 2;
  localparam logic [11:0] ds_status_addr_c = 12'h100;

  typedef struct packed {
    logic        valid;
    logic [7:0]  data;
    logic [15:0] port;
    logic        broadcast;
    logic        unreachable;
  } ds_byte_t;

  typedef struct packed {
    logic        strobe;
    logic        resprqst;
    logic [5:0]  addr;
    logic        ptt;
    logic [31:0] data;
  } ds_cmd_t;

  typedef enum logic [1:0] {
    lane_none,
    lane_lr,
    lane_iq
  } ds_lane_e;

  typedef struct packed {
    logic [15:0] left;
    logic [15:0] right;
  } ds_audio_t;

  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
  } ds_iq_t;

  // Same word, audio or transmit I/Q depending on the lane
  typedef union packed {
    ds_audio_t audio;
    ds_iq_t    iq;
  } ds_sample_u;

  typedef struct packed {
    logic       valid;
    ds_lane_e   kind;
    ds_sample_u word;
  } ds_sample_t;

  // run sits in bit 0, matching the run/stop byte
  typedef struct packed {
    logic [4:0]  reserved;
    logic [15:0] frame_cnt;
    logic [7:0]  discovery_cnt;
    logic        ptt;
    logic        wide_spectrum;
    logic        run;
  } ds_status_t;

endpackage

// File: ds_frame_parser.sv
// Downstream packet parser with run/stop, discovery, command capture and watchdog
module ds_frame_parser
  import sdr_ds_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  ds_byte_t    rx,
  input  logic        watchdog_tick,
  output logic        run,
  output logic        wide_spectrum,
  output logic        discovery,
  output ds_cmd_t     cmd,
  output ds_lane_e    lane,
  output logic [7:0]  lane_byte
);

  typedef enum logic [4:0] {
    st_start, st_preamble, st_decode, st_runstop, st_discovery, st_endpoint,
    st_seq3, st_seq2, st_seq1, st_seq0,
    st_sync2, st_sync1, st_sync0, st_cmdctrl,
    st_cmddata3, st_cmddata2, st_cmddata1, st_cmddata0, st_push
  } state_e;

  state_e      state_q, state_d;
  logic        run_q, run_d;
  logic        wide_q, wide_d;
  logic        frame_q, frame_d;
  logic [5:0]  slot_q, slot_d;
  logic [2:0]  byte_idx_q, byte_idx_d;
  logic        strobe_d;
  logic        cmd_strobe_q;
  logic        cmd_resprqst_q;
  logic [5:0]  cmd_addr_q;
  logic        cmd_ptt_q;
  logic [31:0] cmd_data_q;
  logic [3:0]  watchdog_cnt;
  logic        watchdog_clr;
  logic        watchdog_expired;
  logic        port_ok;

  assign port_ok = (rx.port == ds_port_c);
  assign watchdog_expired = &watchdog_cnt;

  always_comb begin
    state_d      = st_start;
    run_d        = run_q;
    wide_d       = wide_q;
    frame_d      = frame_q;
    slot_d       = slot_q;
    byte_idx_d   = byte_idx_q;
    strobe_d     = 1'b0;
    watchdog_clr = 1'b0;
    discovery    = 1'b0;
    lane         = lane_none;
    // A gap in the stream always restarts the packet search
    if (rx.valid) begin
      case (state_q)
        st_start: begin
          frame_d = 1'b0;
          if (rx.data == ds_preamble0_c && port_ok) state_d = st_preamble;
        end
        st_preamble: if (rx.data == ds_preamble1_c && port_ok) state_d = st_decode;
        st_decode: begin
          if (rx.data == ds_kind_data_c) state_d = st_endpoint;
          else if (rx.data == ds_kind_runstop_c) state_d = st_runstop;
          else if (rx.data == ds_kind_disc_c && rx.broadcast) state_d = st_discovery;
        end
        st_runstop: begin
          run_d  = rx.data[0];
          wide_d = rx.data[1];
        end
        st_discovery: discovery = 1'b1;
        st_endpoint: if (rx.data == ds_endpoint_c) state_d = st_seq3;
        st_seq3: state_d = st_seq2;
        st_seq2: state_d = st_seq1;
        st_seq1: state_d = st_seq0;
        st_seq0: begin
          // Host is alive, restart the watchdog
          watchdog_clr = 1'b1;
          state_d = st_sync2;
        end
        // Sync loss keeps hunting for the next sync byte
        st_sync2: state_d = (rx.data == ds_sync_c) ? st_sync1 : st_sync2;
        st_sync1: state_d = (rx.data == ds_sync_c) ? st_sync0 : st_sync2;
        st_sync0: state_d = (rx.data == ds_sync_c) ? st_cmdctrl : st_sync2;
        st_cmdctrl: state_d = st_cmddata3;
        st_cmddata3: state_d = st_cmddata2;
        st_cmddata2: state_d = st_cmddata1;
        st_cmddata1: state_d = st_cmddata0;
        st_cmddata0: begin
          strobe_d   = 1'b1;
          slot_d     = '0;
          byte_idx_d = '0;
          state_d    = st_push;
        end
        st_push: begin
          // L1 L0 R1 R0 then I1 I0 Q1 Q0
          lane       = byte_idx_q[2] ? lane_iq : lane_lr;
          byte_idx_d = byte_idx_q + 3'd1;
          state_d    = st_push;
          if (byte_idx_q == 3'd7) begin
            slot_d = slot_q + 6'd1;
            if (slot_q == 6'(ds_samples_per_frame_c - 1)) begin
              if (frame_q != 1'(ds_frames_per_packet_c - 1)) begin
                frame_d = frame_q + 1'b1;
                state_d = st_sync2;
              end else begin
                state_d = st_start;
              end
            end
          end
        end
        default: state_d = st_start;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q      <= st_start;
      run_q        <= 1'b0;
      wide_q       <= 1'b0;
      frame_q      <= 1'b0;
      slot_q       <= '0;
      byte_idx_q   <= '0;
      cmd_strobe_q <= 1'b0;
    end else begin
      frame_q      <= frame_d;
      slot_q       <= slot_d;
      byte_idx_q   <= byte_idx_d;
      cmd_strobe_q <= strobe_d;
      if (rx.unreachable || watchdog_expired) begin
        state_q <= st_start;
        run_q   <= 1'b0;
        wide_q  <= 1'b0;
      end else begin
        state_q <= state_d;
        run_q   <= run_d;
        wide_q  <= wide_d;
      end
    end
  end

  // Command fields, data arrives MSB first
  always_ff @(posedge clk) begin
    if (rx.valid) begin
      case (state_q)
        st_cmdctrl: {cmd_resprqst_q, cmd_addr_q, cmd_ptt_q} <= rx.data;
        st_cmddata3, st_cmddata2, st_cmddata1, st_cmddata0:
          cmd_data_q <= {cmd_data_q[23:0], rx.data};
        default: ;
      endcase
    end
  end

  // Stops the radio when the host goes quiet
  always_ff @(posedge clk) begin
    if (reset || !run_q || watchdog_clr) begin
      watchdog_cnt <= '0;
    end else if (watchdog_tick && !watchdog_expired) begin
      watchdog_cnt <= watchdog_cnt + 4'd1;
    end
  end

  assign run           = run_q;
  assign wide_spectrum = wide_q;
  assign lane_byte     = rx.data;
  assign cmd = '{strobe: cmd_strobe_q, resprqst: cmd_resprqst_q, addr: cmd_addr_q,
                 ptt: cmd_ptt_q, data: cmd_data_q};

endmodule

// File: ds_sample_packer.sv
// Sample packer, four steered bytes into one tagged audio or I/Q word
module ds_sample_packer
  import sdr_ds_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  ds_lane_e   lane,
  input  logic [7:0] lane_byte,
  output ds_sample_t sample
);

  logic [31:0] hold_q;
  logic [1:0]  cnt_q;
  logic        valid_q;
  ds_lane_e    kind_q;
  logic        active;

  assign active = (lane != lane_none);

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q   <= '0;
      valid_q <= 1'b0;
      kind_q  <= lane_none;
    end else begin
      valid_q <= active && (cnt_q == 2'd3);
      if (active) begin
        cnt_q  <= cnt_q + 2'd1;
        kind_q <= lane;
      end else begin
        // Realign on every gap between groups
        cnt_q <= '0;
      end
    end
  end

  // Big-endian, first byte ends up in the top
  always_ff @(posedge clk) begin
    if (active) hold_q <= {hold_q[23:0], lane_byte};
  end

  // The kind tag tells audio from I/Q
  always_comb begin
    sample.valid = valid_q;
    sample.kind  = kind_q;
    sample.word  = hold_q;
  end

endmodule

// File: ds_cmd_regfile.sv
// Command register bank, ptt and counters, with APB read port
module ds_cmd_regfile
  import sdr_ds_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  ds_cmd_t     cmd,
  input  logic        run,
  input  logic        wide_spectrum,
  input  logic        discovery,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic [31:0] regs_q [64];
  logic        ptt_q;
  logic [7:0]  disc_cnt_q;
  logic [15:0] frame_cnt_q;
  ds_status_t  status;

  always_ff @(posedge clk) begin
    if (cmd.strobe) regs_q[cmd.addr] <= cmd.data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ptt_q       <= 1'b0;
      disc_cnt_q  <= '0;
      frame_cnt_q <= '0;
    end else begin
      if (cmd.strobe) begin
        ptt_q       <= cmd.ptt;
        frame_cnt_q <= frame_cnt_q + 16'd1;
      end
      if (discovery) disc_cnt_q <= disc_cnt_q + 8'd1;
    end
  end

  always_comb begin
    status               = '0;
    status.run           = run;
    status.wide_spectrum = wide_spectrum;
    status.ptt           = ptt_q;
    status.discovery_cnt = disc_cnt_q;
    status.frame_cnt     = frame_cnt_q;
  end

  // Read-only slave, no wait states
  assign pready  = psel && penable;
  assign pslverr = psel && penable && pwrite;

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (paddr == ds_status_addr_c) prdata = status;
      else if (paddr[11:8] == 4'h0 && paddr[1:0] == 2'b00) prdata = regs_q[paddr[7:2]];
    end
  end

endmodule

// File: ds_unpack_top.sv
// Downstream unpacker top level, parser, sample packer and command registers
module ds_unpack_top
  import sdr_ds_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  ds_byte_t    rx,
  input  logic        watchdog_tick,
  output logic        run,
  output logic        wide_spectrum,
  output logic        discovery,
  output ds_sample_t  sample,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  ds_cmd_t    cmd;
  ds_lane_e   lane;
  logic [7:0] lane_byte;

  ds_frame_parser i_parser (
    .clk           (clk),
    .reset         (reset),
    .rx            (rx),
    .watchdog_tick (watchdog_tick),
    .run           (run),
    .wide_spectrum (wide_spectrum),
    .discovery     (discovery),
    .cmd           (cmd),
    .lane          (lane),
    .lane_byte     (lane_byte)
  );

  ds_sample_packer i_packer (
    .clk       (clk),
    .reset     (reset),
    .lane      (lane),
    .lane_byte (lane_byte),
    .sample    (sample)
  );

  ds_cmd_regfile i_regfile (
    .clk           (clk),
    .reset         (reset),
    .cmd           (cmd),
    .run           (run),
    .wide_spectrum (wide_spectrum),
    .discovery     (discovery),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr)
  );

endmodule

// File: tb_ds_unpack.sv
// Testbench for the downstream unpacker, trace driven packets with sample and APB checks
module tb_ds_unpack
  import sdr_ds_pkg::*;
();

  typedef logic [5:0][31:0] args_t;

  logic        clk;
  logic        reset;
  ds_byte_t    rx;
  logic        watchdog_tick;
  logic        run;
  logic        wide_spectrum;
  logic        discovery;
  ds_sample_t  sample;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  string       rec_name[$];
  string       rec_op[$];
  args_t       rec_args[$];
  logic [33:0] expect_q[$];
  logic [31:0] lcg_state = 32'h1573_2ee3;
  int          cycle_limit = 0;
  int          disc_pulses = 0;
  int          test_checks = 0;
  int          test_errs = 0;
  int          total_checks = 0;
  int          total_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  ds_unpack_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [7:0] rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  task automatic compare_word(input string what, input logic [31:0] got,
                              input logic [31:0] want);
    test_checks++;
    assert (got === want) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, want);
      test_errs++;
    end
  endtask

  task automatic drive_byte(input logic [7:0] value, input logic [15:0] port, input logic bcast);
    @(posedge clk);
    rx <= '{valid: 1'b1, data: value, port: port, broadcast: bcast, unreachable: 1'b0};
  endtask

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      rx <= '0;
      watchdog_tick <= 1'b0;
    end
  endtask

  task automatic run_stop_packet(input logic [7:0] b);
    drive_byte(ds_preamble0_c, ds_port_c, 1'b0);
    drive_byte(ds_preamble1_c, ds_port_c, 1'b0);
    drive_byte(ds_kind_runstop_c, ds_port_c, 1'b0);
    drive_byte(b, ds_port_c, 1'b0);
    drive_idle(3);
    // Bit 0 is run, bit 1 is wide spectrum
    compare_word("run", 32'(run), 32'(b[0]));
    compare_word("wide_spectrum", 32'(wide_spectrum), 32'(b[1]));
  endtask

  task automatic discovery_packet(input logic bcast);
    disc_pulses = 0;
    drive_byte(ds_preamble0_c, ds_port_c, bcast);
    drive_byte(ds_preamble1_c, ds_port_c, bcast);
    drive_byte(ds_kind_disc_c, ds_port_c, bcast);
    drive_byte(8'h00, ds_port_c, bcast);
    drive_idle(3);
    compare_word("discovery pulses", disc_pulses, 32'(bcast));
  endtask

  task automatic data_packet(input args_t a);
    logic [15:0] port;
    logic        accept;
    logic [7:0]  b [8];
    port   = a[0][15:0];
    accept = (port == ds_port_c) && (a[5] == 0);
    drive_byte((a[5] == 2) ? 8'hee : ds_preamble0_c, port, 1'b0);
    drive_byte(ds_preamble1_c, port, 1'b0);
    drive_byte(ds_kind_data_c, port, 1'b0);
    drive_byte(ds_endpoint_c, port, 1'b0);
    repeat (4) drive_byte(8'h00, port, 1'b0);
    for (int f = 0; f < ds_frames_per_packet_c; f++) begin
      drive_byte((a[5] == 1) ? 8'h00 : ds_sync_c, port, 1'b0);
      repeat (2) drive_byte(ds_sync_c, port, 1'b0);
      drive_byte(a[1 + 2 * f][7:0], port, 1'b0);
      for (int k = 3; k >= 0; k--) drive_byte(a[2 + 2 * f][8 * k +: 8], port, 1'b0);
      for (int s = 0; s < ds_samples_per_frame_c; s++) begin
        for (int k = 0; k < 8; k++) b[k] = rand_byte();
        // Queued ahead of the bytes, L1 L0 R1 R0 then I1 I0 Q1 Q0
        if (accept) begin
          expect_q.push_back({lane_lr, b[0], b[1], b[2], b[3]});
          expect_q.push_back({lane_iq, b[4], b[5], b[6], b[7]});
        end
        for (int k = 0; k < 8; k++) drive_byte(b[k], port, 1'b0);
      end
    end
    drive_idle(4);
  endtask

  task automatic pulse_ticks(input int n);
    repeat (n) begin
      @(posedge clk);
      watchdog_tick <= 1'b1;
      @(posedge clk);
      watchdog_tick <= 1'b0;
    end
    drive_idle(3);
  endtask

  task automatic flag_unreachable();
    @(posedge clk);
    rx <= '{valid: 1'b0, data: 8'h00, port: ds_port_c, broadcast: 1'b0, unreachable: 1'b1};
    drive_idle(2);
    compare_word("run after unreachable", 32'(run), 32'd0);
    compare_word("wide_spectrum after unreachable", 32'(wide_spectrum), 32'd0);
  endtask

  task automatic apb_access(input logic write, input logic [11:0] addr, input logic [31:0] value);
    @(posedge clk);
    psel   <= 1'b1;
    pwrite <= write;
    paddr  <= addr;
    pwdata <= value;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    compare_word("pready", 32'(pready), 32'd1);
    compare_word("pslverr", 32'(pslverr), 32'(write));
    if (!write) compare_word($sformatf("prdata at %h", addr), prdata, value);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    drive_idle(4);
    test_checks++;
    assert (expect_q.size() == 0) else begin
      $display("%0d expected samples never came out in test %s", expect_q.size(), name);
      test_errs++;
    end
    expect_q.delete();
    $display("test %s %s, %0d checks, %0d errors", name,
             (test_errs == 0) ? "passed" : "FAILED", test_checks, test_errs);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    total_checks += test_checks;
    total_errs   += test_errs;
    test_checks  = 0;
    test_errs    = 0;
  endtask

  task automatic read_trace();
    int          fd;
    int          n;
    int          budget;
    string       line;
    string       nm;
    string       op;
    logic [31:0] f0, f1, f2, f3, f4, f5;
    budget = 500;
    fd = $fopen("ds_unpack_trace.txt", "r");
    total_checks++;
    assert (fd != 0) else begin
      $display("cannot open the trace file ds_unpack_trace.txt");
      total_errs++;
    end
    if (fd != 0) begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() < 3 || line[0] == "#") continue;
        n = $sscanf(line, "%s %s %h %h %h %h %h %h", nm, op, f0, f1, f2, f3, f4, f5);
        if (n != 8) begin
          $display("malformed trace line: %s", line);
          total_errs++;
          continue;
        end
        rec_name.push_back(nm);
        rec_op.push_back(op);
        rec_args.push_back({f5, f4, f3, f2, f1, f0});
        // Two cycles per tick pulse
        if (op == "data") budget += 1100;
        else if (op == "ticks") budget += 2 * f0;
        else budget += 20;
      end
      $fclose(fd);
    end
    cycle_limit = budget;
  endtask

  always @(posedge clk) begin
    if (discovery) disc_pulses++;
  end

  // Sample stream against the queue built from the LCG bytes
  always @(posedge clk) begin : sample_check
    logic [33:0] want;
    if (!reset && sample.valid) begin
      test_checks++;
      assert (expect_q.size() > 0) else begin
        $display("sample came out at %0t with none expected", $time);
        test_errs++;
      end
      if (expect_q.size() > 0) begin
        want = expect_q.pop_front();
        compare_word("sample kind", 32'(sample.kind), 32'(want[33:32]));
        // Audio reads as left and right, transmit as i and q
        if (want[33:32] == lane_iq) begin
          compare_word("sample i", 32'(sample.word.iq.i), 32'(want[31:16]));
          compare_word("sample q", 32'(sample.word.iq.q), 32'(want[15:0]));
        end else begin
          compare_word("sample left", 32'(sample.word.audio.left), 32'(want[31:16]));
          compare_word("sample right", 32'(sample.word.audio.right), 32'(want[15:0]));
        end
      end
    end
  end

  initial begin : hang_guard
    int cycles;
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run hung, still going after %0d cycles", cycle_limit);
    $display("Something failed");
    $finish;
  end

  initial begin : main_sequence
    string cur;
    args_t a;
    reset         = 1'b1;
    rx            = '0;
    watchdog_tick = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    cur           = "";
    read_trace();
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    for (int r = 0; r < rec_op.size(); r++) begin
      if (cur != "" && rec_name[r] != cur) finish_test(cur);
      cur = rec_name[r];
      a   = rec_args[r];
      case (rec_op[r])
        "runstop": run_stop_packet(a[0][7:0]);
        "disc":    discovery_packet(a[0][0]);
        "data":    data_packet(a);
        "ticks":   pulse_ticks(a[0]);
        "unreach": flag_unreachable();
        "read":    apb_access(1'b0, a[0][11:0], a[1]);
        "write":   apb_access(1'b1, a[0][11:0], a[1]);
        default: begin
          $display("unknown operation %s in the trace", rec_op[r]);
          test_errs++;
        end
      endcase
    end
    if (cur != "") finish_test(cur);
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, total_checks, total_errs);
    if (total_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: ds_unpack_trace.txt
# test op f1..f6 (hex, unused zero). runstop: byte. disc: broadcast. ticks: count. unreach.
# data: port ctrl0 word0 ctrl1 word1 corrupt (1 sync, 2 preamble). read: addr want. write: addr data
runstop runstop 03 0 0 0 0 0
runstop read 100 00000003 0 0 0 0
runstop runstop 00 0 0 0 0 0
runstop read 100 00000000 0 0 0 0
commands data 0400 02 12345678 0b deadbeef 0
commands read 004 12345678 0 0 0 0
commands read 014 deadbeef 0 0 0 0
commands read 100 00001004 0 0 0 0
commands data 0400 81 cafef00d 7e 0badc0de 0
commands read 000 cafef00d 0 0 0 0
commands read 0fc 0badc0de 0 0 0 0
commands read 100 00002000 0 0 0 0
filter disc 1 0 0 0 0 0
filter disc 0 0 0 0 0 0
filter read 100 00002008 0 0 0 0
filter data 0401 02 11111111 0a 22222222 0
filter data 0400 02 11111111 0a 22222222 2
filter data 0400 02 11111111 0a 22222222 1
filter read 004 12345678 0 0 0 0
filter read 014 deadbeef 0 0 0 0
filter read 100 00002008 0 0 0 0
watchdog runstop 01 0 0 0 0 0
watchdog ticks 0e 0 0 0 0 0
watchdog data 0400 10 00000008 12 00000009 0
watchdog ticks 0e 0 0 0 0 0
watchdog read 100 00003009 0 0 0 0
watchdog read 020 00000008 0 0 0 0
watchdog data 0400 14 0000000a 16 0000000b 0
watchdog ticks 0f 0 0 0 0 0
watchdog read 100 00004008 0 0 0 0
unreach runstop 03 0 0 0 0 0
unreach unreach 0 0 0 0 0 0
unreach read 100 00004008 0 0 0 0
apb write 004 ffffffff 0 0 0 0
apb read 004 12345678 0 0 0 0
apb read 204 00000000 0 0 0 0
apb read 101 00000000 0 0 0 0

// File: verilog.f
sdr_ds_pkg.sv
ds_frame_parser.sv
ds_sample_packer.sv
ds_cmd_regfile.sv
ds_unpack_top.sv
tb_ds_unpack.sv

// File: Bender.yml
package:
  name: sdr_ds_unpack

sources:
  - sdr_ds_pkg.sv
  - ds_frame_parser.sv
  - ds_sample_packer.sv
  - ds_cmd_regfile.sv
  - ds_unpack_top.sv
  - target: test
    files:
      - tb_ds_unpack.sv
